// File: hw/alu32.sv
`include "cpu_consts.svh"
`default_nettype none

module alu32 (
  input  wire                   clk,
  input  wire                   rst,
  input  wire  [`DATA_W-1:0]    read_data1,
  input  wire  [`DATA_W-1:0]    read_data2,
  input  wire  [`DATA_W-1:0]    imm_value,
  input  wire                   imm_reg_select,
  input  wire cpu_pkg::alu_sub_e alu_op,
  output logic [`DATA_W-1:0]    alu_result,
  output logic [`DM_ADDR_W-1:0] dm_address
);

  logic [`DATA_W-1:0]   operand2;
  logic [4:0]           shamt;
  logic [2*`DATA_W-1:0] rot_pair;
  logic [`DATA_W-1:0]   result;

  assign operand2 = imm_reg_select ? imm_value : read_data2;
  assign shamt    = operand2[4:0];

  // A doubled word shifted right gives the rotate in its low half.
  assign rot_pair = {read_data1, read_data1} >> shamt;

  always_comb begin
    case (alu_op)
      cpu_pkg::ADD:   result = read_data1 + operand2;
      cpu_pkg::SUB:   result = read_data1 - operand2;
      cpu_pkg::AND:   result = read_data1 & operand2;
      cpu_pkg::OR:    result = read_data1 | operand2;
      cpu_pkg::XOR:   result = read_data1 ^ operand2;
      cpu_pkg::SRLI:  result = read_data1 >> shamt;
      cpu_pkg::SLLI:  result = read_data1 << shamt;
      cpu_pkg::ROTRI: result = rot_pair[`DATA_W-1:0];
      default:        result = '0;
    endcase
  end

  // The word address for lwi and swi is valid in S_EXEC.
  assign dm_address = result[`DM_ADDR_W-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      alu_result <= '0;
    end else begin
      alu_result <= result;
    end
  end

endmodule

`default_nettype wire

// File: hw/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`default_nettype none

// Datapath and instruction word width.
`define DATA_W 32

// Word address widths of the two memory ports.
`define IM_ADDR_W 10
`define DM_ADDR_W 12

// Register index width for 32 registers.
`define REG_ADDR_W 5

// Free-running counter widths.
`define CYCLE_W 128
`define INS_W 64

`default_nettype wire

`endif

// File: hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // Major opcode, instruction bits 30 to 25.
  typedef enum logic [5:0] {
    NOP     = 6'b000000,
    LWI     = 6'b000010,
    SWI     = 6'b001010,
    ALU_REG = 6'b100000,
    MOVI    = 6'b100010,
    ADDI    = 6'b101000,
    XORI    = 6'b101011,
    ORI     = 6'b101100
  } opcode_e;

  // Sub-opcode under ALU_REG, instruction bits 4 to 0.
  typedef enum logic [4:0] {
    ADD   = 5'b00000,
    SUB   = 5'b00001,
    AND   = 5'b00010,
    XOR   = 5'b00011,
    OR    = 5'b00100,
    SLLI  = 5'b01000,
    SRLI  = 5'b01001,
    ROTRI = 5'b01011
  } alu_sub_e;

  typedef enum logic [1:0] {
    IMM5       = 2'd0,
    IMM15_SEXT = 2'd1,
    IMM15_ZEXT = 2'd2,
    IMM20_SEXT = 2'd3
  } imm_sel_e;

  typedef enum logic [1:0] {
    S_FETCH  = 2'd0,
    S_DECODE = 2'd1,
    S_EXEC   = 2'd2,
    S_WB     = 2'd3
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: hw/cpu_top.sv
`include "cpu_consts.svh"
`default_nettype none

module cpu_top (
  input  wire                   clk,
  input  wire                   rst,
  input  wire  [`DATA_W-1:0]    instruction,
  input  wire  [`DATA_W-1:0]    dm_out,
  output wire  [`IM_ADDR_W-1:0] im_address,
  output wire                   im_read,
  output wire                   im_enable,
  output wire  [`DM_ADDR_W-1:0] dm_address,
  output wire  [`DATA_W-1:0]    dm_in,
  output wire                   dm_read,
  output wire                   dm_write,
  output wire                   dm_enable,
  output wire  [`CYCLE_W-1:0]   cycle_cnt,
  output wire  [`INS_W-1:0]     ins_cnt
);

  wire [`IM_ADDR_W-1:0]  pc;
  wire                   pc_advance;
  wire                   reg_read;
  wire                   reg_write;
  wire                   writeback_select;
  wire [`REG_ADDR_W-1:0] read_address1;
  wire [`REG_ADDR_W-1:0] read_address2;
  wire [`REG_ADDR_W-1:0] write_address;
  wire [`DATA_W-1:0]     imm_value;
  wire                   imm_reg_select;
  cpu_pkg::alu_sub_e     alu_op;
  wire [`DATA_W-1:0]     read_data1;
  wire [`DATA_W-1:0]     read_data2;
  wire [`DATA_W-1:0]     alu_result;

  // Store data is the rt operand read in S_DECODE.
  assign dm_in = read_data2;

  pc_tick u_pc_tick (
    .clk        (clk),
    .rst        (rst),
    .pc_advance (pc_advance),
    .pc         (pc),
    .cycle_cnt  (cycle_cnt)
  );

  ir_controller u_ir_controller (
    .clk              (clk),
    .rst              (rst),
    .instruction      (instruction),
    .pc               (pc),
    .im_address       (im_address),
    .im_read          (im_read),
    .im_enable        (im_enable),
    .dm_read          (dm_read),
    .dm_write         (dm_write),
    .dm_enable        (dm_enable),
    .reg_read         (reg_read),
    .reg_write        (reg_write),
    .writeback_select (writeback_select),
    .read_address1    (read_address1),
    .read_address2    (read_address2),
    .write_address    (write_address),
    .imm_value        (imm_value),
    .imm_reg_select   (imm_reg_select),
    .alu_op           (alu_op),
    .pc_advance       (pc_advance),
    .ins_cnt          (ins_cnt)
  );

  regfile u_regfile (
    .read_address1    (read_address1),
    .read_address2    (read_address2),
    .write_address    (write_address),
    .clk              (clk),
    .rst              (rst),
    .reg_read         (reg_read),
    .reg_write        (reg_write),
    .writeback_select (writeback_select),
    .alu_result       (alu_result),
    .dm_out           (dm_out),
    .read_data1       (read_data1),
    .read_data2       (read_data2)
  );

  alu32 u_alu32 (
    .clk            (clk),
    .rst            (rst),
    .read_data1     (read_data1),
    .read_data2     (read_data2),
    .imm_value      (imm_value),
    .imm_reg_select (imm_reg_select),
    .alu_op         (alu_op),
    .alu_result     (alu_result),
    .dm_address     (dm_address)
  );

endmodule

`default_nettype wire

// File: hw/ir_controller.sv
`include "cpu_consts.svh"
`default_nettype none

module ir_controller (
  input  wire                    clk,
  input  wire                    rst,
  input  wire  [`DATA_W-1:0]     instruction,
  input  wire  [`IM_ADDR_W-1:0]  pc,
  output logic [`IM_ADDR_W-1:0]  im_address,
  output logic                   im_read,
  output logic                   im_enable,
  output logic                   dm_read,
  output logic                   dm_write,
  output logic                   dm_enable,
  output logic                   reg_read,
  output logic                   reg_write,
  output logic                   writeback_select,
  output logic [`REG_ADDR_W-1:0] read_address1,
  output logic [`REG_ADDR_W-1:0] read_address2,
  output logic [`REG_ADDR_W-1:0] write_address,
  output logic [`DATA_W-1:0]     imm_value,
  output logic                   imm_reg_select,
  output cpu_pkg::alu_sub_e      alu_op,
  output logic                   pc_advance,
  output logic [`INS_W-1:0]      ins_cnt
);

  cpu_pkg::ctrl_state_e   state;
  logic                   run;
  logic [`DATA_W-1:0]     ir;
  logic [`DATA_W-1:0]     cur_ins;
  cpu_pkg::opcode_e       opcode;
  cpu_pkg::alu_sub_e      sub_op;
  cpu_pkg::imm_sel_e      imm_sel;
  logic [`REG_ADDR_W-1:0] rt;
  logic [`REG_ADDR_W-1:0] ra;
  logic [`REG_ADDR_W-1:0] rb;
  logic                   writes_reg;
  logic                   is_load;
  logic                   is_store;

  // The first fetch starts one cycle after reset is released.
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= cpu_pkg::S_FETCH;
      run     <= 1'b0;
      ins_cnt <= '0;
    end else if (!run) begin
      run <= 1'b1;
    end else begin
      case (state)
        cpu_pkg::S_FETCH:  state <= cpu_pkg::S_DECODE;
        cpu_pkg::S_DECODE: state <= cpu_pkg::S_EXEC;
        cpu_pkg::S_EXEC:   state <= cpu_pkg::S_WB;
        default:           state <= cpu_pkg::S_FETCH;
      endcase
      if (state == cpu_pkg::S_WB) begin
        ins_cnt <= ins_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == cpu_pkg::S_DECODE) begin
      ir <= instruction;
    end
  end

  // Decode straight from the memory word while the IR is being loaded.
  assign cur_ins = (state == cpu_pkg::S_DECODE) ? instruction : ir;

  assign opcode = cpu_pkg::opcode_e'(cur_ins[30:25]);
  assign sub_op = cpu_pkg::alu_sub_e'(cur_ins[4:0]);
  assign rt     = cur_ins[24:20];
  assign ra     = cur_ins[19:15];
  assign rb     = cur_ins[14:10];

  always_comb begin
    alu_op         = cpu_pkg::ADD;
    imm_sel        = cpu_pkg::IMM15_SEXT;
    imm_reg_select = 1'b1;
    read_address1  = ra;
    writes_reg     = 1'b0;
    is_load        = 1'b0;
    is_store       = 1'b0;
    case (opcode)
      cpu_pkg::ALU_REG: begin
        alu_op  = sub_op;
        imm_sel = cpu_pkg::IMM5;
        case (sub_op)
          cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::AND, cpu_pkg::OR, cpu_pkg::XOR: begin
            imm_reg_select = 1'b0;
            writes_reg     = 1'b1;
          end
          cpu_pkg::SRLI, cpu_pkg::SLLI, cpu_pkg::ROTRI: begin
            writes_reg = 1'b1;
          end
          default: begin
            writes_reg = 1'b0;
          end
        endcase
      end
      cpu_pkg::ADDI: begin
        writes_reg = 1'b1;
      end
      cpu_pkg::ORI: begin
        alu_op     = cpu_pkg::OR;
        imm_sel    = cpu_pkg::IMM15_ZEXT;
        writes_reg = 1'b1;
      end
      cpu_pkg::XORI: begin
        alu_op     = cpu_pkg::XOR;
        imm_sel    = cpu_pkg::IMM15_ZEXT;
        writes_reg = 1'b1;
      end
      cpu_pkg::MOVI: begin
        // r0 OR imm20.
        alu_op        = cpu_pkg::OR;
        imm_sel       = cpu_pkg::IMM20_SEXT;
        read_address1 = '0;
        writes_reg    = 1'b1;
      end
      cpu_pkg::LWI: begin
        writes_reg = 1'b1;
        is_load    = 1'b1;
      end
      cpu_pkg::SWI: begin
        is_store = 1'b1;
      end
      default: begin
        writes_reg = 1'b0;
      end
    endcase
  end

  always_comb begin
    case (imm_sel)
      cpu_pkg::IMM5:       imm_value = {{(`DATA_W-5){1'b0}}, rb};
      cpu_pkg::IMM15_SEXT: imm_value = {{(`DATA_W-15){cur_ins[14]}}, cur_ins[14:0]};
      cpu_pkg::IMM15_ZEXT: imm_value = {{(`DATA_W-15){1'b0}}, cur_ins[14:0]};
      default:             imm_value = {{(`DATA_W-20){cur_ins[19]}}, cur_ins[19:0]};
    endcase
  end

  // Stores read rt on the second port so it reaches dm_in.
  assign read_address2 = is_store ? rt : rb;
  assign write_address = rt;

  assign im_address       = pc;
  assign im_read          = run && (state == cpu_pkg::S_FETCH);
  assign im_enable        = im_read;
  assign reg_read         = (state == cpu_pkg::S_DECODE);
  assign dm_read          = (state == cpu_pkg::S_EXEC) && is_load;
  assign dm_write         = (state == cpu_pkg::S_EXEC) && is_store;
  assign dm_enable        = dm_read || dm_write;
  assign reg_write        = (state == cpu_pkg::S_WB) && writes_reg;
  assign writeback_select = is_load;
  assign pc_advance       = (state == cpu_pkg::S_WB);

endmodule

`default_nettype wire

// File: hw/pc_tick.sv
`include "cpu_consts.svh"
`default_nettype none

module pc_tick (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   pc_advance,
  output logic [`IM_ADDR_W-1:0] pc,
  output logic [`CYCLE_W-1:0]   cycle_cnt
);

  // Word program counter, one step per retired instruction.
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (pc_advance) begin
      pc <= pc + 1'b1;
    end
  end

  // Counts every clock out of reset.
  always_ff @(posedge clk) begin
    if (rst) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hw/regfile.sv
`include "cpu_consts.svh"
`default_nettype none

module regfile (
  input  wire  [`REG_ADDR_W-1:0] read_address1,
  input  wire  [`REG_ADDR_W-1:0] read_address2,
  input  wire  [`REG_ADDR_W-1:0] write_address,
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    reg_read,
  input  wire                    reg_write,
  input  wire                    writeback_select,
  input  wire  [`DATA_W-1:0]     alu_result,
  input  wire  [`DATA_W-1:0]     dm_out,
  output logic [`DATA_W-1:0]     read_data1,
  output logic [`DATA_W-1:0]     read_data2
);

  logic [`DATA_W-1:0] regs [0:(1 << `REG_ADDR_W)-1];
  logic [`DATA_W-1:0] write_data;

  // Loads write back the memory word.
  assign write_data = writeback_select ? dm_out : alu_result;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < (1 << `REG_ADDR_W); i++) begin
        regs[i] <= '0;
      end
    end else if (reg_write) begin
      regs[write_address] <= write_data;
    end
  end

  // Operands are held for the ALU through S_EXEC.
  always_ff @(posedge clk) begin
    if (rst) begin
      read_data1 <= '0;
      read_data2 <= '0;
    end else if (reg_read) begin
      read_data1 <= regs[read_address1];
      read_data2 <= regs[read_address2];
    end
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+hw
hw/cpu_pkg.sv
hw/pc_tick.sv
hw/ir_controller.sv
hw/regfile.sv
hw/alu32.sv
hw/cpu_top.sv
verif/cpu_properties.sv
verif/cpu_checker.sv
verif/cpu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator.
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module cpu_tb -f list.f -o cpu_sim
./obj_dir/cpu_sim +verilator+error+limit+100 | tee sim.log
if grep -q "SIMULATION PASSED" sim.log; then
  exit 0
fi
exit 1

// File: verif/cpu_checker.sv
`include "cpu_consts.svh"
`default_nettype none

module cpu_checker #(
  parameter int          N_INS    = 120,
  parameter int          IM_DEPTH = 256,
  parameter logic [31:0] FILL_TAG = 32'h0
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   prog_ready,
  input  logic [`DATA_W-1:0]    prog [0:IM_DEPTH-1],
  input  wire  [`IM_ADDR_W-1:0] im_address,
  input  wire                   im_read,
  input  wire  [`DM_ADDR_W-1:0] dm_address,
  input  wire  [`DATA_W-1:0]    dm_in,
  input  wire                   dm_read,
  input  wire                   dm_write,
  input  wire  [`CYCLE_W-1:0]   cycle_cnt,
  input  wire  [`INS_W-1:0]     ins_cnt,
  output int unsigned           value_errors,
  output int unsigned           other_errors,
  output logic                  run_done,
  output logic                  timed_out
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = N_INS * 4 + 100;

  logic [`DATA_W-1:0]    ref_regs [0:31];
  logic [`DATA_W-1:0]    ref_mem [0:(1 << `DM_ADDR_W)-1];
  logic [`DM_ADDR_W-1:0] exp_store_addr [$];
  logic [`DATA_W-1:0]    exp_store_data [$];
  logic [`DM_ADDR_W-1:0] exp_load_addr [$];
  int unsigned           value_errs = 0;
  int unsigned           other_errs = 0;
  logic                  done_flag = 1'b0;
  logic                  timeout_flag = 1'b0;
  int                    fetch_k = 0;
  int                    cycles = 0;
  logic [`CYCLE_W-1:0]   fetch_cycle = '0;

  assign value_errors = value_errs;
  assign other_errors = other_errs;
  assign run_done     = done_flag;
  assign timed_out    = timeout_flag;

  // Register result of one instruction, or the word address for lwi and swi.
  function automatic logic [`DATA_W-1:0] model_result(input logic [`DATA_W-1:0] ins,
                                                      input logic [`DATA_W-1:0] a,
                                                      input logic [`DATA_W-1:0] b);
    logic [4:0]         sh;
    logic [`DATA_W-1:0] s15;
    logic [`DATA_W-1:0] z15;
    sh  = ins[14:10];
    s15 = {{17{ins[14]}}, ins[14:0]};
    z15 = {17'd0, ins[14:0]};
    case (ins[30:25])
      cpu_pkg::ALU_REG: begin
        case (ins[4:0])
          cpu_pkg::ADD:   return a + b;
          cpu_pkg::SUB:   return a - b;
          cpu_pkg::AND:   return a & b;
          cpu_pkg::OR:    return a | b;
          cpu_pkg::XOR:   return a ^ b;
          cpu_pkg::SRLI:  return a >> sh;
          cpu_pkg::SLLI:  return a << sh;
          cpu_pkg::ROTRI: return (a >> sh) | (a << (6'd32 - {1'b0, sh}));
          default:        return '0;
        endcase
      end
      cpu_pkg::ADDI, cpu_pkg::LWI, cpu_pkg::SWI: return a + s15;
      cpu_pkg::ORI:  return a | z15;
      cpu_pkg::XORI: return a ^ z15;
      cpu_pkg::MOVI: return {{12{ins[19]}}, ins[19:0]};
      default:       return '0;
    endcase
  endfunction

  function automatic bit writes_register(input logic [`DATA_W-1:0] ins);
    case (ins[30:25])
      cpu_pkg::ADDI, cpu_pkg::ORI, cpu_pkg::XORI, cpu_pkg::MOVI: return 1'b1;
      cpu_pkg::ALU_REG: return ins[4:0] inside {cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::AND,
                                                cpu_pkg::OR, cpu_pkg::XOR, cpu_pkg::SRLI,
                                                cpu_pkg::SLLI, cpu_pkg::ROTRI};
      default: return 1'b0;
    endcase
  endfunction

  task automatic run_reference();
    logic [`DATA_W-1:0]    ins;
    logic [`DATA_W-1:0]    res;
    logic [`DM_ADDR_W-1:0] addr;
    for (int r = 0; r < 32; r++) begin
      ref_regs[r] = '0;
    end
    for (int a = 0; a < (1 << `DM_ADDR_W); a++) begin
      ref_mem[a] = FILL_TAG | 32'(a);
    end
    for (int i = 0; i < N_INS; i++) begin
      ins  = prog[i];
      res  = model_result(ins, ref_regs[ins[19:15]], ref_regs[ins[14:10]]);
      addr = res[`DM_ADDR_W-1:0];
      if (ins[30:25] == cpu_pkg::SWI) begin
        exp_store_addr.push_back(addr);
        exp_store_data.push_back(ref_regs[ins[24:20]]);
        ref_mem[addr] = ref_regs[ins[24:20]];
      end else if (ins[30:25] == cpu_pkg::LWI) begin
        exp_load_addr.push_back(addr);
        ref_regs[ins[24:20]] = ref_mem[addr];
      end else if (writes_register(ins)) begin
        ref_regs[ins[24:20]] = res;
      end
    end
  endtask

  task automatic report_mismatch(input string name, input logic [`CYCLE_W-1:0] exp,
                                 input logic [`CYCLE_W-1:0] act);
    $display("CHECK FAILED at %0t ns: %s expected %0h, actual %0h", $time, name, exp, act);
    value_errs++;
  endtask

  task automatic report_fault(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    other_errs++;
  endtask

  task automatic check_fetch();
    if (int'(im_address) != fetch_k) begin
      report_mismatch("im_address", fetch_k, im_address);
    end
    if (ins_cnt != fetch_k) begin
      report_mismatch("ins_cnt", fetch_k, ins_cnt);
    end
    // The first fetch comes one cycle after reset is released.
    if (cycle_cnt != 4 * fetch_k + 1) begin
      report_mismatch("cycle_cnt", 4 * fetch_k + 1, cycle_cnt);
    end
    fetch_cycle = cycle_cnt;
    if (fetch_k == N_INS) begin
      if (exp_store_addr.size() != 0 || exp_load_addr.size() != 0) begin
        report_fault("program ended with expected memory accesses still missing");
      end
      done_flag = 1'b1;
    end
    fetch_k++;
  endtask

  task automatic check_data_access();
    logic [`DM_ADDR_W-1:0] exp_addr;
    logic [`DATA_W-1:0]    exp_data;
    if (cycle_cnt != fetch_cycle + 2) begin
      report_fault("data memory strobe outside the execute cycle");
    end
    if (dm_write && exp_store_addr.size() == 0) begin
      report_fault("store seen where none was expected");
    end else if (dm_write) begin
      exp_addr = exp_store_addr.pop_front();
      exp_data = exp_store_data.pop_front();
      if (dm_address != exp_addr) begin
        report_mismatch("dm_address", exp_addr, dm_address);
      end
      if (dm_in != exp_data) begin
        report_mismatch("dm_in", exp_data, dm_in);
      end
    end
    if (dm_read && exp_load_addr.size() == 0) begin
      report_fault("load seen where none was expected");
    end else if (dm_read) begin
      exp_addr = exp_load_addr.pop_front();
      if (dm_address != exp_addr) begin
        report_mismatch("dm_address", exp_addr, dm_address);
      end
    end
  endtask

  initial begin
    wait (prog_ready);
    run_reference();
  end

  // Outputs are sampled half a cycle after the DUT updates them.
  always @(negedge clk) begin
    cycles++;
    if (rst) begin
      if (im_read !== 1'b0 || dm_read !== 1'b0 || dm_write !== 1'b0) begin
        report_fault("memory strobe high during reset");
      end
      if (cycle_cnt !== '0) begin
        report_mismatch("cycle_cnt", '0, cycle_cnt);
      end
      if (ins_cnt !== '0) begin
        report_mismatch("ins_cnt", '0, ins_cnt);
      end
    end else if (!done_flag && !timeout_flag) begin
      if (im_read) begin
        check_fetch();
      end
      if (dm_read || dm_write) begin
        check_data_access();
      end
    end
    if (!done_flag && !timeout_flag && cycles >= TIMEOUT_CYCLES) begin
      report_fault($sformatf("timeout after %0d cycles with %0d instructions fetched",
                             cycles, fetch_k));
      timeout_flag = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verif/cpu_properties.sv
`default_nettype none

module cpu_properties (
  input wire clk,
  input wire rst,
  input wire im_read,
  input wire im_enable,
  input wire dm_read,
  input wire dm_write,
  input wire dm_enable
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;

  // No memory traffic while the core is held in reset or in the cycle after.
  reset_quiet: assert property (@(posedge clk)
    rst |=> !(im_read || im_enable || dm_read || dm_write || dm_enable))
    else begin
      $error("memory strobe asserted during reset");
      fail_count++;
    end

  dm_exclusive: assert property (@(posedge clk) disable iff (rst) !(dm_read && dm_write))
    else begin
      $error("dm_read and dm_write high together");
      fail_count++;
    end

  dm_enabled: assert property (@(posedge clk) disable iff (rst)
    (dm_read || dm_write) |-> dm_enable)
    else begin
      $error("data memory strobe without dm_enable");
      fail_count++;
    end

  // Fetches are four cycles apart.
  fetch_spacing: assert property (@(posedge clk) disable iff (rst)
    im_read |-> !$past(im_read, 1) && !$past(im_read, 2) && !$past(im_read, 3))
    else begin
      $error("im_read repeated within three cycles");
      fail_count++;
    end

endmodule

bind cpu_top cpu_properties u_props (
  .clk       (clk),
  .rst       (rst),
  .im_read   (im_read),
  .im_enable (im_enable),
  .dm_read   (dm_read),
  .dm_write  (dm_write),
  .dm_enable (dm_enable)
);

`default_nettype wire

// File: verif/cpu_tb.sv
`include "cpu_consts.svh"
`default_nettype none

module cpu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          N_INS    = 120;
  localparam int          IM_DEPTH = 256;
  localparam logic [31:0] FILL_TAG = 32'hDA7A_0000;
  localparam logic [4:0]  SUB_OPS [8] = '{cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::AND, cpu_pkg::OR,
                                          cpu_pkg::XOR, cpu_pkg::SRLI, cpu_pkg::SLLI,
                                          cpu_pkg::ROTRI};

  logic                  clk = 1'b0;
  logic                  rst;
  logic [`DATA_W-1:0]    instruction = '0;
  logic [`DATA_W-1:0]    dm_out = '0;
  wire  [`IM_ADDR_W-1:0] im_address;
  wire                   im_read;
  wire                   im_enable;
  wire  [`DM_ADDR_W-1:0] dm_address;
  wire  [`DATA_W-1:0]    dm_in;
  wire                   dm_read;
  wire                   dm_write;
  wire                   dm_enable;
  wire  [`CYCLE_W-1:0]   cycle_cnt;
  wire  [`INS_W-1:0]     ins_cnt;

  logic [`DATA_W-1:0] prog [0:IM_DEPTH-1];
  logic [`DATA_W-1:0] dmem [0:(1 << `DM_ADDR_W)-1];
  logic               prog_ready;
  logic               run_done;
  logic               timed_out;
  int unsigned        value_errors;
  int unsigned        other_errors;

  function automatic logic [31:0] enc_reg(input logic [4:0] sub, input logic [4:0] rt,
                                          input logic [4:0] ra, input logic [4:0] rb);
    return {1'b0, cpu_pkg::ALU_REG, rt, ra, rb, 5'd0, sub};
  endfunction

  function automatic logic [31:0] enc_imm(input logic [5:0] op, input logic [4:0] rt,
                                          input logic [4:0] ra, input logic [14:0] imm15);
    return {1'b0, op, rt, ra, imm15};
  endfunction

  // Random operations each followed by a store of the result.
  task automatic build_program();
    logic [11:0] stored [$];
    logic [11:0] addr;
    logic [4:0]  rt;
    logic [4:0]  ra;
    logic [4:0]  rb;
    int          kind;
    int          pick;
    int          n;
    for (int i = 0; i < IM_DEPTH; i++) begin
      prog[i] = '0;
    end
    for (n = 0; n < 8; n++) begin
      prog[n] = {1'b0, cpu_pkg::MOVI, 5'(n + 1), 20'($urandom)};
    end
    while (n < N_INS) begin
      kind = $urandom_range(12, 0);
      rt   = 5'($urandom_range(15, 1));
      ra   = 5'($urandom_range(15, 1));
      rb   = (kind >= 5 && kind < 8) ? 5'($urandom) : 5'($urandom_range(15, 1));
      if (kind == 12 && stored.size() != 0) begin
        pick    = $urandom_range(stored.size() - 1, 0);
        prog[n] = enc_imm(cpu_pkg::LWI, rt, 5'd0, {3'd0, stored[pick]});
      end else if (kind < 8) begin
        prog[n] = enc_reg(SUB_OPS[kind], rt, ra, rb);
      end else if (kind == 8) begin
        prog[n] = enc_imm(cpu_pkg::ADDI, rt, ra, 15'($urandom));
      end else if (kind == 9) begin
        prog[n] = enc_imm(cpu_pkg::ORI, rt, ra, 15'($urandom));
      end else if (kind == 10) begin
        prog[n] = enc_imm(cpu_pkg::XORI, rt, ra, 15'($urandom));
      end else begin
        prog[n] = {1'b0, cpu_pkg::MOVI, rt, 20'($urandom)};
      end
      addr        = 12'($urandom);
      prog[n + 1] = enc_imm(cpu_pkg::SWI, rt, 5'd0, {3'd0, addr});
      stored.push_back(addr);
      n += 2;
    end
  endtask

  initial begin
    forever #4 clk = ~clk;
  end

  initial begin
    rst        = 1'b1;
    prog_ready = 1'b0;
    void'($urandom(20));
    for (int a = 0; a < (1 << `DM_ADDR_W); a++) begin
      dmem[a] = FILL_TAG | 32'(a);
    end
    build_program();
    prog_ready = 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
  end

  // Registered instruction memory that returns NOP past the program.
  always @(posedge clk) begin
    if (im_read && im_enable) begin
      instruction <= (int'(im_address) < IM_DEPTH) ? prog[im_address[7:0]] : '0;
    end
  end

  always @(posedge clk) begin
    if (dm_enable && dm_write) begin
      dmem[dm_address] <= dm_in;
    end
    if (dm_enable && dm_read) begin
      dm_out <= dmem[dm_address];
    end
  end

  cpu_top i_cpu_top (
    .clk         (clk),
    .rst         (rst),
    .instruction (instruction),
    .dm_out      (dm_out),
    .im_address  (im_address),
    .im_read     (im_read),
    .im_enable   (im_enable),
    .dm_address  (dm_address),
    .dm_in       (dm_in),
    .dm_read     (dm_read),
    .dm_write    (dm_write),
    .dm_enable   (dm_enable),
    .cycle_cnt   (cycle_cnt),
    .ins_cnt     (ins_cnt)
  );

  cpu_checker #(.N_INS(N_INS), .IM_DEPTH(IM_DEPTH), .FILL_TAG(FILL_TAG)) u_checker (
    .clk          (clk),
    .rst          (rst),
    .prog_ready   (prog_ready),
    .prog         (prog),
    .im_address   (im_address),
    .im_read      (im_read),
    .dm_address   (dm_address),
    .dm_in        (dm_in),
    .dm_read      (dm_read),
    .dm_write     (dm_write),
    .cycle_cnt    (cycle_cnt),
    .ins_cnt      (ins_cnt),
    .value_errors (value_errors),
    .other_errors (other_errors),
    .run_done     (run_done),
    .timed_out    (timed_out)
  );

  initial begin
    wait (run_done || timed_out);
    $display("Error counts: %0d value, %0d other, %0d assertion", value_errors, other_errors,
             i_cpu_top.u_props.fail_count);
    if (timed_out || value_errors != 0 || other_errors != 0 ||
        i_cpu_top.u_props.fail_count != 0) begin
      $display("SIMULATION FAILED");
    end else begin
      $display("SIMULATION PASSED");
    end
    $finish;
  end

endmodule

`default_nettype wire
